/* include/roic_tg_params.svh */
`ifndef ROIC_TG_PARAMS_SVH
`define ROIC_TG_PARAMS_SVH

// ==========================================================================
// timing generator sizes
// ==========================================================================
`define TG_NUM_CH        13         // IRST..DF_SM5
`define TG_PHASE_W       8          // 256 phases per line
`define TG_CNT_W         11         // up to 2048 clocks per line
`define TG_GATE_CH       6          // bit of GATE in the pulse vector

// channel i answers at base + i
`define TG_ADDR_BASE     8'h20

// ==========================================================================
// rise/fall values loaded at reset
// ==========================================================================
`define TG_DEF_RISE_IRST    8'd1
`define TG_DEF_FALL_IRST    8'd5
`define TG_DEF_RISE_SHR     8'd6
`define TG_DEF_FALL_SHR     8'd40
`define TG_DEF_RISE_SHS     8'd41
`define TG_DEF_FALL_SHS     8'd254
`define TG_DEF_RISE_LPF1    8'd16
`define TG_DEF_FALL_LPF1    8'd41
`define TG_DEF_RISE_LPF2    8'd229
`define TG_DEF_FALL_LPF2    8'd255
`define TG_DEF_RISE_TDEF    8'd128
`define TG_DEF_FALL_TDEF    8'd255
`define TG_DEF_RISE_GATE    8'd128
`define TG_DEF_FALL_GATE    8'd255
// shared by DF_SM0 to DF_SM5
`define TG_DEF_RISE_DF_SM   8'd128
`define TG_DEF_FALL_DF_SM   8'd255

`endif

/* source/roic_tg_pkg.sv */
`include "roic_tg_params.svh"

package roic_tg_pkg;

    // ==========================================================================
    // widths with a meaning
    // ==========================================================================
    typedef logic [`TG_PHASE_W-1:0] phase_t;       // line phase, rise and fall
    typedef logic [`TG_CNT_W-1:0]   line_cnt_t;    // clock count within a line
    typedef logic [1:0]             scan_range_t;  // line is 256 << str clocks
    typedef logic [7:0]             reg_addr_t;
    typedef logic [15:0]            reg_data_t;
    typedef logic [`TG_NUM_CH-1:0]  pulse_vec_t;   // one bit per channel

    // ==========================================================================
    // bundles
    // ==========================================================================
    typedef struct packed {
        phase_t rise;                               // upper byte of a write
        phase_t fall;
    } edge_pair_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    typedef struct packed {
        phase_t phase;
        logic   step;                               // phase advances here
        logic   line_end;                           // last count of the line
        logic   sync_fire;                          // accepted frame sync
    } line_tick_t;

    // frame sync request handshake
    typedef enum logic [1:0] {
        SYNC_IDLE,
        SYNC_WAIT,
        SYNC_ACK
    } sync_state_t;

endpackage

/* source/timing_reg_bank.sv */
`timescale 1ns/1ps
`include "roic_tg_params.svh"

module timing_reg_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  roic_tg_pkg::reg_wr_t     reg_wr,
    input  logic                     bank_sel,
    input  roic_tg_pkg::line_tick_t  tick,
    output roic_tg_pkg::edge_pair_t  edges [`TG_NUM_CH]
);

    roic_tg_pkg::reg_wr_t wr_q;        // write port, one stage
    logic                 wr_bank_a;   // bank_sel travelling with the write

    // reset value of one channel
    function automatic roic_tg_pkg::edge_pair_t default_edge(input int unsigned ch);
        roic_tg_pkg::edge_pair_t e;
        case (ch)
            0: begin
                e.rise = `TG_DEF_RISE_IRST;
                e.fall = `TG_DEF_FALL_IRST;
            end
            1: begin
                e.rise = `TG_DEF_RISE_SHR;
                e.fall = `TG_DEF_FALL_SHR;
            end
            2: begin
                e.rise = `TG_DEF_RISE_SHS;
                e.fall = `TG_DEF_FALL_SHS;
            end
            3: begin
                e.rise = `TG_DEF_RISE_LPF1;
                e.fall = `TG_DEF_FALL_LPF1;
            end
            4: begin
                e.rise = `TG_DEF_RISE_LPF2;
                e.fall = `TG_DEF_FALL_LPF2;
            end
            5: begin
                e.rise = `TG_DEF_RISE_TDEF;
                e.fall = `TG_DEF_FALL_TDEF;
            end
            6: begin
                e.rise = `TG_DEF_RISE_GATE;
                e.fall = `TG_DEF_FALL_GATE;
            end
            default: begin
                e.rise = `TG_DEF_RISE_DF_SM;    // DF_SM0..5
                e.fall = `TG_DEF_FALL_DF_SM;
            end
        endcase
        return e;
    endfunction

    // ==========================================================================
    // write port register
    // ==========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_q      <= '0;
            wr_bank_a <= 1'b0;
        end else begin
            wr_q      <= reg_wr;
            wr_bank_a <= bank_sel;              // 1 selects bank A
        end
    end

    // ==========================================================================
    // per channel: two standby banks and the active set
    // ==========================================================================
    for (genvar i = 0; i < `TG_NUM_CH; i++) begin : g_ch
        roic_tg_pkg::edge_pair_t bank_a;
        roic_tg_pkg::edge_pair_t bank_b;
        roic_tg_pkg::edge_pair_t active;
        logic                    wr_hit;

        assign wr_hit = wr_q.en &&
                        (wr_q.addr == roic_tg_pkg::reg_addr_t'(`TG_ADDR_BASE + i));

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                bank_a <= default_edge(i);
                bank_b <= default_edge(i);
                active <= default_edge(i);
            end else begin
                if (wr_hit && wr_bank_a) begin
                    bank_a <= roic_tg_pkg::edge_pair_t'(wr_q.data);
                end
                if (wr_hit && !wr_bank_a) begin
                    bank_b <= roic_tg_pkg::edge_pair_t'(wr_q.data);
                end
                if (tick.sync_fire) begin
                    active <= bank_sel ? bank_b : bank_a;   // take the idle bank
                end
            end
        end

        assign edges[i] = active;
    end

endmodule

/* source/line_sequencer.sv */
`timescale 1ns/1ps

module line_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  roic_tg_pkg::scan_range_t  str,
    input  logic                      sync_req,
    output roic_tg_pkg::line_tick_t   tick,
    output logic                      sync_ack,
    output logic                      roic_a_bz
);

    roic_tg_pkg::line_cnt_t    cnt;
    roic_tg_pkg::line_cnt_t    cnt_last;     // 256 << str, minus one
    roic_tg_pkg::line_cnt_t    step_mask;    // low str bits
    roic_tg_pkg::sync_state_t  state;
    roic_tg_pkg::sync_state_t  state_nxt;
    logic                      line_end;
    logic                      sync_fire;
    logic                      a_bz;

    // ==========================================================================
    // line counter and phase
    // ==========================================================================
    always_comb begin
        cnt_last  = (roic_tg_pkg::line_cnt_t'(256) << str) - 1'b1;
        step_mask = (roic_tg_pkg::line_cnt_t'(1) << str) - 1'b1;
    end

    assign line_end = (cnt == cnt_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (line_end) begin
            cnt <= '0;                           // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        tick.phase     = roic_tg_pkg::phase_t'(cnt >> str);
        tick.step      = ((cnt & step_mask) == '0);
        tick.line_end  = line_end;
        tick.sync_fire = sync_fire;
    end

    // a/b line toggle, restarts on an accepted sync
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_bz <= 1'b0;
        end else if (sync_fire) begin
            a_bz <= 1'b0;
        end else if (line_end) begin
            a_bz <= ~a_bz;
        end
    end

    // ==========================================================================
    // sync request handshake
    // ==========================================================================
    // only at the end of a b line
    assign sync_fire = (state == roic_tg_pkg::SYNC_WAIT) && line_end && !a_bz;

    always_comb begin
        state_nxt = state;
        case (state)
            roic_tg_pkg::SYNC_IDLE: begin
                if (sync_req) begin
                    state_nxt = roic_tg_pkg::SYNC_WAIT;
                end
            end
            roic_tg_pkg::SYNC_WAIT: begin
                if (sync_fire) begin
                    state_nxt = roic_tg_pkg::SYNC_ACK;
                end
            end
            roic_tg_pkg::SYNC_ACK: begin
                if (!sync_req) begin
                    state_nxt = roic_tg_pkg::SYNC_IDLE;   // requester let go
                end
            end
            default: state_nxt = roic_tg_pkg::SYNC_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= roic_tg_pkg::SYNC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign sync_ack  = (state == roic_tg_pkg::SYNC_ACK);
    assign roic_a_bz = a_bz;

endmodule

/* source/pulse_channel.sv */
`timescale 1ns/1ps

module pulse_channel (
    input  logic                     clk,
    input  logic                     rst,
    input  roic_tg_pkg::line_tick_t  tick,
    input  roic_tg_pkg::edge_pair_t  edge_cfg,
    output logic                     level
);

    logic hit_rise;
    logic hit_fall;

    assign hit_rise = (tick.phase == edge_cfg.rise);
    assign hit_fall = (tick.phase == edge_cfg.fall);

    // ==========================================================================
    // pulse level, moves only on phase steps
    // ==========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level <= 1'b0;
        end else if (tick.sync_fire) begin
            level <= 1'b0;                       // new frame starts low
        end else if (tick.step) begin
            if (hit_rise) begin
                level <= 1'b1;                   // rise wins a tie
            end else if (hit_fall) begin
                level <= 1'b0;
            end
        end
    end

endmodule

/* source/pulse_output_stage.sv */
`timescale 1ns/1ps
`include "roic_tg_params.svh"

module pulse_output_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  roic_tg_pkg::pulse_vec_t  levels,
    input  logic                     aed_skip_oe,
    output roic_tg_pkg::pulse_vec_t  pulses,
    output logic                     gate_on,
    output logic                     tg_oe
);

    logic gate_lvl;

    assign gate_lvl = levels[`TG_GATE_CH];

    // ==========================================================================
    // output registers
    // ==========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pulses  <= '0;
            gate_on <= 1'b0;
            tg_oe   <= 1'b0;
        end else begin
            pulses  <= levels;
            gate_on <= gate_lvl;
            // AED skip forces the gate driver enabled
            tg_oe   <= aed_skip_oe | ~gate_lvl;
        end
    end

endmodule

/* source/roic_tg_top.sv */
`timescale 1ns/1ps
`include "roic_tg_params.svh"

module roic_tg_top (
    input  logic                      clk,
    input  logic                      rst,
    input  roic_tg_pkg::scan_range_t  str,
    input  roic_tg_pkg::reg_wr_t      reg_wr,
    input  logic                      bank_sel,
    input  logic                      sync_req,
    input  logic                      aed_skip_oe,
    output logic                      sync_ack,
    output logic                      roic_sync_out,
    output logic                      roic_a_bz,
    output roic_tg_pkg::pulse_vec_t   pulses,
    output logic                      gate_on,
    output logic                      tg_oe
);

    roic_tg_pkg::line_tick_t  tick;
    roic_tg_pkg::edge_pair_t  edges [`TG_NUM_CH];
    roic_tg_pkg::pulse_vec_t  levels;              // raw channel levels

    // ==========================================================================
    // timing values and line timing
    // ==========================================================================
    timing_reg_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .bank_sel (bank_sel),
        .tick     (tick),
        .edges    (edges)
    );

    line_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .str       (str),
        .sync_req  (sync_req),
        .tick      (tick),
        .sync_ack  (sync_ack),
        .roic_a_bz (roic_a_bz)
    );

    assign roic_sync_out = tick.sync_fire;

    // ==========================================================================
    // pulse channels, IRST first, DF_SM5 last
    // ==========================================================================
    for (genvar i = 0; i < `TG_NUM_CH; i++) begin : g_pulse
        pulse_channel u_ch (
            .clk      (clk),
            .rst      (rst),
            .tick     (tick),
            .edge_cfg (edges[i]),
            .level    (levels[i])
        );
    end

    pulse_output_stage u_out (
        .clk         (clk),
        .rst         (rst),
        .levels      (levels),
        .aed_skip_oe (aed_skip_oe),
        .pulses      (pulses),
        .gate_on     (gate_on),
        .tg_oe       (tg_oe)
    );

endmodule

/* testbench/roic_tg_sva.sv */
`timescale 1ns/1ps

module roic_tg_sva (
    input logic clk,
    input logic rst,
    input logic sync_req,
    input logic sync_ack,
    input logic roic_sync_out,
    input logic roic_a_bz,
    input logic line_end,
    input logic aed_skip_oe,
    input logic gate_on,
    input logic tg_oe
);

    int fail_cnt = 0;

    ack_after_fire: assert property (@(posedge clk) disable iff (rst)
        $rose(sync_ack) |-> $past(roic_sync_out))
        else begin
            fail_cnt++;
            $error("sync_ack rose without a frame sync the cycle before");
        end

    ack_held: assert property (@(posedge clk) disable iff (rst)
        sync_ack && sync_req |=> sync_ack)
        else begin
            fail_cnt++;
            $error("sync_ack dropped while sync_req was still high");
        end

    a_bz_toggle: assert property (@(posedge clk) disable iff (rst)
        line_end && !roic_sync_out |=> roic_a_bz != $past(roic_a_bz))
        else begin
            fail_cnt++;
            $error("roic_a_bz did not toggle at a line end");
        end

    // skip override, else gate driver off while the gate is on
    oe_rule: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> tg_oe == ($past(aed_skip_oe) | ~gate_on))
        else begin
            fail_cnt++;
            $error("tg_oe does not follow aed_skip_oe and gate_on");
        end

endmodule

/* testbench/roic_tg_checker.sv */
`timescale 1ns/1ps
`include "roic_tg_params.svh"

module roic_tg_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  roic_tg_pkg::scan_range_t  str,
    input  roic_tg_pkg::reg_wr_t      reg_wr,
    input  logic                      bank_sel,
    input  logic                      aed_skip_oe,
    input  logic                      sync_ack,
    input  logic                      roic_sync_out,
    input  logic                      roic_a_bz,
    input  roic_tg_pkg::pulse_vec_t   pulses,
    input  logic                      gate_on,
    input  logic                      tg_oe,
    output int                        err_cnt
);

    roic_tg_pkg::edge_pair_t  bank_a [`TG_NUM_CH];
    roic_tg_pkg::edge_pair_t  bank_b [`TG_NUM_CH];
    roic_tg_pkg::edge_pair_t  active [`TG_NUM_CH];
    roic_tg_pkg::reg_wr_t     wr_d;              // write port stage
    logic                     wr_d_bank_a;
    roic_tg_pkg::pulse_vec_t  lvl;               // modelled channel levels
    roic_tg_pkg::pulse_vec_t  exp_pulses;
    logic                     exp_tg_oe;
    logic                     a_bz_m;            // modelled a/b line toggle
    logic                     sync_s;            // roic_sync_out seen at the falling edge
    logic                     synced;
    logic                     valid;
    logic                     rst_s;
    int unsigned              cnt;
    int unsigned              since_rst;
    int                       errs = 0;

    assign err_cnt = errs;

    // rise wins a tie
    function automatic logic next_level(input logic cur, input roic_tg_pkg::phase_t ph,
                                        input roic_tg_pkg::edge_pair_t e);
        return (ph == e.rise) ? 1'b1 : ((ph == e.fall) ? 1'b0 : cur);
    endfunction

    function automatic roic_tg_pkg::edge_pair_t reset_pair(input int ch);
        case (ch)
            0:       return {`TG_DEF_RISE_IRST, `TG_DEF_FALL_IRST};
            1:       return {`TG_DEF_RISE_SHR, `TG_DEF_FALL_SHR};
            2:       return {`TG_DEF_RISE_SHS, `TG_DEF_FALL_SHS};
            3:       return {`TG_DEF_RISE_LPF1, `TG_DEF_FALL_LPF1};
            4:       return {`TG_DEF_RISE_LPF2, `TG_DEF_FALL_LPF2};
            5:       return {`TG_DEF_RISE_TDEF, `TG_DEF_FALL_TDEF};
            6:       return {`TG_DEF_RISE_GATE, `TG_DEF_FALL_GATE};
            default: return {`TG_DEF_RISE_DF_SM, `TG_DEF_FALL_DF_SM};
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errs++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ==========================================================================
    // model, inputs taken at the rising edge
    // ==========================================================================
    always @(posedge clk) begin
        rst_s <= rst;
        if (rst) begin
            for (int i = 0; i < `TG_NUM_CH; i++) begin
                bank_a[i] <= reset_pair(i);
                bank_b[i] <= reset_pair(i);
                active[i] <= reset_pair(i);
            end
            wr_d      <= '0;
            lvl       <= '0;
            cnt       <= 0;
            a_bz_m    <= 1'b0;
            synced    <= 1'b0;
            valid     <= 1'b0;
            since_rst <= 0;
        end else begin
            wr_d        <= reg_wr;
            wr_d_bank_a <= bank_sel;
            exp_pulses  <= lvl;                  // output register
            exp_tg_oe   <= aed_skip_oe | ~lvl[`TG_GATE_CH];
            valid       <= synced;
            since_rst   <= (since_rst < 8) ? since_rst + 1 : since_rst;
            for (int i = 0; i < `TG_NUM_CH; i++) begin
                if (wr_d.en && wr_d.addr == `TG_ADDR_BASE + i) begin
                    if (wr_d_bank_a) begin
                        bank_a[i] <= wr_d.data;
                    end else begin
                        bank_b[i] <= wr_d.data;
                    end
                end
            end
            if (sync_s) begin
                for (int i = 0; i < `TG_NUM_CH; i++) begin
                    active[i] <= bank_sel ? bank_b[i] : bank_a[i];
                end
                lvl    <= '0;
                cnt    <= 0;                     // sync cycle is the last count
                a_bz_m <= 1'b0;
                synced <= 1'b1;
            end else begin
                if (synced && (cnt % (1 << str)) == 0) begin
                    for (int i = 0; i < `TG_NUM_CH; i++) begin
                        lvl[i] <= next_level(lvl[i], roic_tg_pkg::phase_t'(cnt >> str),
                                             active[i]);
                    end
                end
                if (cnt == (256 << str) - 1) begin
                    a_bz_m <= ~a_bz_m;
                end
                cnt <= (cnt == (256 << str) - 1) ? 0 : cnt + 1;
            end
        end
    end

    // ==========================================================================
    // compare at the falling edge
    // ==========================================================================
    always @(negedge clk) begin
        sync_s <= roic_sync_out;
        if (rst_s) begin
            compare_value("tg_oe", tg_oe, 0);
            compare_value("pulses", pulses, 0);
        end else if (since_rst == 1) begin       // first clock after reset
            compare_value("pulses", pulses, 0);
            compare_value("gate_on", gate_on, 0);
            compare_value("tg_oe", tg_oe, 1);
            compare_value("sync_ack", sync_ack, 0);
            compare_value("roic_sync_out", roic_sync_out, 0);
            compare_value("roic_a_bz", roic_a_bz, 0);
        end else if (valid) begin
            compare_value("pulses", pulses, exp_pulses);
            compare_value("gate_on", gate_on, exp_pulses[`TG_GATE_CH]);
            compare_value("tg_oe", tg_oe, exp_tg_oe);
            compare_value("roic_a_bz", roic_a_bz, a_bz_m);
            if (roic_sync_out && (cnt != (256 << str) - 1 || a_bz_m)) begin
                errs++;
                $display("roic_sync_out away from the end of a b line at %0t", $time);
            end
        end
    end

endmodule

/* testbench/roic_tg_tb.sv */
`timescale 1ns/1ps
`include "roic_tg_params.svh"

module roic_tg_tb;

    localparam int LINES_T2 = 6;                 // short lines after the first sync
    localparam int LINES_T3 = 6;
    localparam int LINES_T4 = 2;                 // long lines after each sync
    // a sync may wait up to two lines
    localparam int SHORT_CYC   = (2 + LINES_T2 + 1 + 2 + LINES_T3) * 256;
    localparam int LONG_CYC    = 2 * (2 + LINES_T4) * 1024;
    localparam int WATCHDOG_NS = 4 * (SHORT_CYC + LONG_CYC + 600);

    logic                      clk;
    logic                      rst;
    roic_tg_pkg::scan_range_t  str;
    roic_tg_pkg::reg_wr_t      reg_wr;
    logic                      bank_sel;
    logic                      sync_req;
    logic                      aed_skip_oe;
    logic                      sync_ack;
    logic                      roic_sync_out;
    logic                      roic_a_bz;
    roic_tg_pkg::pulse_vec_t   pulses;
    logic                      gate_on;
    logic                      tg_oe;
    logic [31:0]               lfsr_state = 32'hf27584f5;
    int                        hs_errs = 0;  // handshake timeouts
    int                        chk_errs;

    roic_tg_top dut0 (.*);

    roic_tg_checker chk0 (.*, .err_cnt(chk_errs));

    bind roic_tg_top roic_tg_sva u_sva (.*, .line_end(tick.line_end));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic apply_reset(input roic_tg_pkg::scan_range_t range);
        rst = 1'b1;
        str = range;                             // only changes under reset
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic write_edge(input int ch, input roic_tg_pkg::phase_t rise,
                              input roic_tg_pkg::phase_t fall);
        @(negedge clk);
        reg_wr.en   = 1'b1;
        reg_wr.addr = roic_tg_pkg::reg_addr_t'(`TG_ADDR_BASE + ch);
        reg_wr.data = {rise, fall};              // rise in the upper byte
        @(negedge clk);
        reg_wr.en   = 1'b0;
    endtask

    task automatic do_sync();
        int wait_cyc;
        int limit;
        limit = 3 * (256 << str) + 16;
        @(negedge clk);
        sync_req = 1'b1;
        wait_cyc = 0;
        while (sync_ack !== 1'b1 && wait_cyc < limit) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (sync_ack !== 1'b1) begin
            $display("sync_ack did not rise within %0d cycles of sync_req", limit);
            hs_errs++;
        end
        sync_req = 1'b0;
        wait_cyc = 0;
        while (sync_ack !== 1'b0 && wait_cyc < 4) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (sync_ack !== 1'b0) begin
            $display("sync_ack stayed high after sync_req fell");
            hs_errs++;
        end
        repeat (take_bits(4)) @(negedge clk);   // idle gap before the next request
    endtask

    task automatic run_lines(input int n);
        repeat (n * (256 << str)) @(negedge clk);
    endtask

    // ==========================================================================
    // test sequence
    // ==========================================================================
    initial begin
        roic_tg_pkg::phase_t rise_v;
        roic_tg_pkg::phase_t fall_v;
        rst         = 1'b1;
        str         = '0;
        reg_wr      = '0;
        bank_sel    = 1'b0;
        sync_req    = 1'b0;
        aed_skip_oe = 1'b0;
        apply_reset(2'd0);                       // reset values, then default timing
        repeat (4) @(negedge clk);
        do_sync();
        run_lines(LINES_T2);
        @(negedge clk);
        bank_sel = 1'b1;                         // writes land in bank A
        for (int ch = 0; ch <= `TG_NUM_CH; ch++) begin
            rise_v = roic_tg_pkg::phase_t'(take_bits(8));
            fall_v = roic_tg_pkg::phase_t'(take_bits(8));
            write_edge(ch, rise_v, fall_v);      // last one hits no channel
        end
        run_lines(1);
        bank_sel = 1'b0;                         // sync takes bank A
        do_sync();
        run_lines(LINES_T3);
        apply_reset(2'd2);                       // 1024 clock lines
        aed_skip_oe = 1'b1;
        do_sync();
        run_lines(LINES_T4);
        aed_skip_oe = 1'b0;
        do_sync();
        run_lines(LINES_T4);
        repeat (4) @(negedge clk);
        $display("error counts: checker %0d, assertions %0d, handshake %0d",
                 chk_errs, dut0.u_sva.fail_cnt, hs_errs);
        if (chk_errs + dut0.u_sva.fail_cnt + hs_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/roic_tg_pkg.sv
source/timing_reg_bank.sv
source/line_sequencer.sv
source/pulse_channel.sv
source/pulse_output_stage.sv
source/roic_tg_top.sv
testbench/roic_tg_sva.sv
testbench/roic_tg_checker.sv
testbench/roic_tg_tb.sv

/* Bender.yml */
package:
  name: roic_tg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/roic_tg_pkg.sv
      - source/timing_reg_bank.sv
      - source/line_sequencer.sv
      - source/pulse_channel.sv
      - source/pulse_output_stage.sv
      - source/roic_tg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/roic_tg_sva.sv
      - testbench/roic_tg_checker.sv
      - testbench/roic_tg_tb.sv
